// ==== filelist.f ====
+incdir+.
fft_pkg.sv
branch_if.sv
twiddle_sequencer.sv
csd_twiddle_mult.sv
delay_line.sv
butterfly_combine.sv
radix2_twiddle_stage.sv
stage_checker.sv
stage_asserts.sv
tb_radix2_stage.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_radix2_stage -f filelist.f -o tb_sim
	./obj_dir/tb_sim | tee /dev/stderr | grep -q "Verification passed"

clean:
	rm -rf obj_dir

// ==== tb_radix2_stage.sv ====
`include "fft_consts.svh"

module tb_radix2_stage;
  timeunit 1ns;
  timeprecision 100ps;
  import fft_pkg::*;

  localparam int TOTAL_PAIRS    = 8 + 8 + 64 + 24 + 32 + 32;
  localparam int MAX_GAPS       = 2 * 24;  // Up to two idle cycles per pair in test 4
  localparam int TIMEOUT_CYCLES = (TOTAL_PAIRS + MAX_GAPS) * 2 + 100;

  logic    clk = 1'b0;
  logic    rst;
  logic    in_valid;
  sample_t in_even_re;
  sample_t in_even_im;
  sample_t in_odd_re;
  sample_t in_odd_im;
  logic    out_valid;
  logic    out_block_start;
  out_t    out_sum_re;
  out_t    out_sum_im;
  out_t    out_diff_re;
  out_t    out_diff_im;
  int      seed;
  int      test_num;
  logic    test_end;
  int      pending;
  int      total_checks;
  int      total_errors;
  int      cycle_cnt = 0;

  always #10 clk = ~clk;

  radix2_twiddle_stage radix2_twiddle_stage_i (.*);

  stage_checker checker_i (.*);

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles", cycle_cnt);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic sample_t rand_part();
    return sample_t'($random(seed));
  endfunction

  // Bit b of j picks the most negative or most positive value
  function automatic sample_t corner_part(int j, int b);
    return j[b] ? sample_t'(2047) : sample_t'(-2048);
  endfunction

  task automatic send_pair(sample_t er, sample_t ei, sample_t orr, sample_t oi);
    @(posedge clk);
    #2;
    in_valid   = 1'b1;
    in_even_re = er;
    in_even_im = ei;
    in_odd_re  = orr;
    in_odd_im  = oi;
  endtask

  task automatic send_random_pair();
    send_pair(rand_part(), rand_part(), rand_part(), rand_part());
  endtask

  // Junk data on idle cycles must be ignored
  task automatic idle_cycle();
    @(posedge clk);
    #2;
    in_valid   = 1'b0;
    in_even_re = rand_part();
    in_even_im = rand_part();
    in_odd_re  = rand_part();
    in_odd_im  = rand_part();
  endtask

  task automatic finish_test(int num);
    idle_cycle();
    while (pending != 0) idle_cycle();  // Drain the pipeline
    test_num = num;
    test_end = 1'b1;
    idle_cycle();
    test_end = 1'b0;
  endtask

  initial begin
    seed       = 58227;
    rst        = 1'b1;
    in_valid   = 1'b0;
    in_even_re = '0;
    in_even_im = '0;
    in_odd_re  = '0;
    in_odd_im  = '0;
    test_num   = 0;
    test_end   = 1'b0;
    repeat (5) @(posedge clk);
    #2 rst = 1'b0;

    for (int j = 0; j < 8; j++) begin
      if (j % 2 == 0)
        send_pair(sample_t'(100 * (j + 1)), sample_t'(-50 * j), sample_t'(1 << j), '0);
      else
        send_pair(sample_t'(100 * (j + 1)), sample_t'(-50 * j), '0, sample_t'(-(1 << j)));
    end
    finish_test(1);

    for (int j = 0; j < 8; j++)
      send_pair(sample_t'(37 * j - 100), sample_t'(25), sample_t'(256 * (j - 4)),
                sample_t'(300 - 75 * j));
    finish_test(2);

    repeat (64) send_random_pair();  // Starts at pair 16, back in unity
    finish_test(3);

    for (int j = 0; j < 24; j++) begin
      repeat ({$random(seed)} % 3) idle_cycle();
      send_random_pair();
    end
    finish_test(4);

    // Bit 3 of j follows the phase, so every corner shows up once in each phase
    for (int j = 0; j < 32; j++)
      send_pair(corner_part(j, 0), corner_part(j, 1), corner_part(j, 2), corner_part(j, 4));
    finish_test(5);

    repeat (20) send_random_pair();  // Ends inside a W8^1 block
    @(posedge clk);
    #2 rst = 1'b1;  // Pairs still in flight
    repeat (2) @(posedge clk);
    #2 rst = 1'b0;
    repeat (12) send_random_pair();
    finish_test(6);

    $display("Summary: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// ==== stage_asserts.sv ====
module stage_asserts (
  input logic          clk,
  input logic          rst,
  input logic          in_valid,
  input logic          out_valid,
  input logic          out_block_start,
  input fft_pkg::out_t out_sum_re,
  input fft_pkg::out_t out_sum_im,
  input fft_pkg::out_t out_diff_re,
  input fft_pkg::out_t out_diff_im
);
  timeunit 1ns;
  timeprecision 100ps;

  // Three register stages from input to butterfly output
  a_latency: assert property (@(posedge clk) disable iff (rst)
      (!$past(rst, 1) && !$past(rst, 2) && !$past(rst, 3)) |-> out_valid == $past(in_valid, 3))
    else $error("out_valid does not follow in_valid by three cycles");

  a_known: assert property (@(posedge clk) disable iff (rst)
      out_valid |-> !$isunknown({out_block_start, out_sum_re, out_sum_im,
                                 out_diff_re, out_diff_im}))
    else $error("unknown output value while out_valid is high");

  a_reset_clear: assert property (@(posedge clk) $past(rst) |-> !out_valid)
    else $error("out_valid high right after reset");

endmodule

bind radix2_twiddle_stage stage_asserts stage_asserts_i (
  .clk            (clk),
  .rst            (rst),
  .in_valid       (in_valid),
  .out_valid      (out_valid),
  .out_block_start(out_block_start),
  .out_sum_re     (out_sum_re),
  .out_sum_im     (out_sum_im),
  .out_diff_re    (out_diff_re),
  .out_diff_im    (out_diff_im)
);

// ==== stage_checker.sv ====
`include "fft_consts.svh"

module stage_checker (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  input  fft_pkg::sample_t in_even_re,
  input  fft_pkg::sample_t in_even_im,
  input  fft_pkg::sample_t in_odd_re,
  input  fft_pkg::sample_t in_odd_im,
  input  logic             out_valid,
  input  logic             out_block_start,
  input  fft_pkg::out_t    out_sum_re,
  input  fft_pkg::out_t    out_sum_im,
  input  fft_pkg::out_t    out_diff_re,
  input  fft_pkg::out_t    out_diff_im,
  input  int               test_num,
  input  logic             test_end,
  output int               pending,
  output int               total_checks,
  output int               total_errors
);
  timeunit 1ns;
  timeprecision 100ps;
  import fft_pkg::*;

  localparam int     LAT    = 3;
  localparam longint ONE_Q9 = 1 << `TW_FRAC;
  localparam longint COS_Q9 = 362;   // W8^1 real part
  localparam longint SIN_Q9 = -363;  // W8^1 imaginary part

  typedef struct {
    out_t sum_re;
    out_t sum_im;
    out_t diff_re;
    out_t diff_im;
    logic block_start;
    int   stamp;  // Negedge count when the pair went in
  } expect_t;

  expect_t exp_q[$];
  int      cycle = 0;
  int      pair_k = 0;  // Valid pairs since reset
  logic    rst_q = 1'b0;
  int      test_checks = 0;
  int      test_errors = 0;

  initial begin
    pending      = 0;
    total_checks = 0;
    total_errors = 0;
  end

  // Butterfly of the even sample with the twiddled odd sample, all in Q9
  function automatic expect_t reference(sample_t er, sample_t ei, sample_t orr, sample_t oi,
                                        logic unity, logic bs, int stamp);
    expect_t e;
    longint  rot_re;
    longint  rot_im;
    longint  ev_re;
    longint  ev_im;
    if (unity) begin
      rot_re = longint'(orr) * ONE_Q9;
      rot_im = longint'(oi) * ONE_Q9;
    end else begin
      rot_re = longint'(orr) * COS_Q9 - longint'(oi) * SIN_Q9;
      rot_im = longint'(orr) * SIN_Q9 + longint'(oi) * COS_Q9;
    end
    ev_re         = longint'(er) * ONE_Q9;
    ev_im         = longint'(ei) * ONE_Q9;
    e.sum_re      = out_t'(ev_re + rot_re);
    e.sum_im      = out_t'(ev_im + rot_im);
    e.diff_re     = out_t'(ev_re - rot_re);
    e.diff_im     = out_t'(ev_im - rot_im);
    e.block_start = bs;
    e.stamp       = stamp;
    return e;
  endfunction

  task automatic check_value(string name, logic signed [63:0] exp, logic signed [63:0] act);
    test_checks++;
    total_checks++;
    if (act !== exp) begin
      test_errors++;
      total_errors++;
      $display("ERROR at %0t: %s expected %0d, actual %0d", $time, name, exp, act);
    end
  endtask

  task automatic report_failure(string what);
    test_errors++;
    total_errors++;
    $display("At %0t: %s", $time, what);
  endtask

  function automatic string test_name(int n);
    case (n)
      1:       return "unity phase";
      2:       return "W8^1 phase";
      3:       return "random samples";
      4:       return "valid gaps";
      5:       return "extreme values";
      6:       return "reset while streaming";
      default: return "unnamed";
    endcase
  endfunction

  // Inputs and outputs are both stable at the falling edge
  always @(negedge clk) begin
    expect_t e;
    cycle++;
    if (rst) begin
      if (rst_q && out_valid) report_failure("out_valid stayed high during reset");
      exp_q.delete();  // Pairs in flight are dropped by the reset
      pair_k = 0;
    end else begin
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          report_failure("output produced without a matching valid input");
        end else begin
          e = exp_q.pop_front();
          if (cycle - e.stamp != LAT)
            report_failure($sformatf("output came %0d cycles after its input", cycle - e.stamp));
          check_value("out_sum_re", e.sum_re, out_sum_re);
          check_value("out_sum_im", e.sum_im, out_sum_im);
          check_value("out_diff_re", e.diff_re, out_diff_re);
          check_value("out_diff_im", e.diff_im, out_diff_im);
          check_value("out_block_start", e.block_start, out_block_start);
        end
      end else if (exp_q.size() != 0 && cycle - exp_q[0].stamp >= LAT) begin
        report_failure("expected output did not appear");
        void'(exp_q.pop_front());
      end
      if (in_valid) begin
        exp_q.push_back(reference(in_even_re, in_even_im, in_odd_re, in_odd_im,
                                  ((pair_k / `TW_HOLD) % 2) == 0,
                                  (pair_k % `TW_HOLD) == 0, cycle));
        pair_k++;
      end
    end
    rst_q   = rst;
    pending = exp_q.size();
    if (test_end) begin
      $display("Test %0d, %s: %0d checks, %0d errors",
               test_num, test_name(test_num), test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
    end
  end

endmodule

// ==== radix2_twiddle_stage.sv ====
`include "fft_consts.svh"

module radix2_twiddle_stage (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  input  fft_pkg::sample_t in_even_re,
  input  fft_pkg::sample_t in_even_im,
  input  fft_pkg::sample_t in_odd_re,
  input  fft_pkg::sample_t in_odd_im,
  output logic             out_valid,
  output logic             out_block_start,
  output fft_pkg::out_t    out_sum_re,
  output fft_pkg::out_t    out_sum_im,
  output fft_pkg::out_t    out_diff_re,
  output fft_pkg::out_t    out_diff_im
);
  import fft_pkg::*;

  cplx_sample_t even_smp;
  cplx_sample_t odd_smp;
  logic         use_unity;
  logic         block_start;

  branch_if rot_branch ();
  branch_if even_branch ();

  assign even_smp.re = in_even_re;
  assign even_smp.im = in_even_im;
  assign odd_smp.re  = in_odd_re;
  assign odd_smp.im  = in_odd_im;

  twiddle_sequencer twiddle_sequencer_i (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .use_unity  (use_unity),
    .block_start(block_start)
  );

  // Odd sample gets rotated
  csd_twiddle_mult csd_twiddle_mult_i (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .sample     (odd_smp),
    .use_unity  (use_unity),
    .block_start(block_start),
    .rot        (rot_branch.source)
  );

  // Even sample waits for the multiplier
  delay_line delay_line_i (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .sample     (even_smp),
    .block_start(block_start),
    .dly        (even_branch.source)
  );

  butterfly_combine butterfly_combine_i (
    .clk            (clk),
    .rst            (rst),
    .even           (even_branch.sink),
    .rot            (rot_branch.sink),
    .out_valid      (out_valid),
    .out_block_start(out_block_start),
    .sum_re         (out_sum_re),
    .sum_im         (out_sum_im),
    .diff_re        (out_diff_re),
    .diff_im        (out_diff_im)
  );

endmodule

// ==== butterfly_combine.sv ====
`include "fft_consts.svh"

module butterfly_combine (
  input  logic          clk,
  input  logic          rst,
  branch_if.sink        even,
  branch_if.sink        rot,
  output logic          out_valid,
  output logic          out_block_start,
  output fft_pkg::out_t sum_re,
  output fft_pkg::out_t sum_im,
  output fft_pkg::out_t diff_re,
  output fft_pkg::out_t diff_im
);
  import fft_pkg::*;

  logic both_valid;
  out_t even_re_w;
  out_t even_im_w;
  out_t rot_re_w;
  out_t rot_im_w;

  assign both_valid = even.valid & rot.valid;  // Aligned by equal latency

  // Widen before adding so nothing wraps
  assign even_re_w = out_t'(even.re);
  assign even_im_w = out_t'(even.im);
  assign rot_re_w  = out_t'(rot.re);
  assign rot_im_w  = out_t'(rot.im);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid       <= 1'b0;
      out_block_start <= 1'b0;
    end else begin
      out_valid       <= both_valid;
      out_block_start <= both_valid & even.block_start & rot.block_start;
    end
  end

  always_ff @(posedge clk) begin
    if (both_valid) begin
      sum_re  <= even_re_w + rot_re_w;
      sum_im  <= even_im_w + rot_im_w;
      diff_re <= even_re_w - rot_re_w;
      diff_im <= even_im_w - rot_im_w;
    end
  end

endmodule

// ==== delay_line.sv ====
`include "fft_consts.svh"

module delay_line (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  fft_pkg::cplx_sample_t sample,
  input  logic                  block_start,
  branch_if.source              dly
);
  import fft_pkg::*;

  cplx_sample_t         smp_q [`MULT_LAT];
  logic [`MULT_LAT-1:0] vld_q;
  logic [`MULT_LAT-1:0] bs_q;

  // Flags shift with reset
  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
      bs_q  <= '0;
    end else begin
      vld_q[0] <= in_valid;
      bs_q[0]  <= in_valid & block_start;
      for (int i = 1; i < `MULT_LAT; i++) begin
        vld_q[i] <= vld_q[i-1];
        bs_q[i]  <= bs_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    smp_q[0] <= sample;
    for (int i = 1; i < `MULT_LAT; i++) smp_q[i] <= smp_q[i-1];
  end

  // Same Q9 scale as the rotated branch
  assign dly.valid       = vld_q[`MULT_LAT-1];
  assign dly.block_start = bs_q[`MULT_LAT-1];
  assign dly.re          = prod_t'(smp_q[`MULT_LAT-1].re) <<< `TW_FRAC;
  assign dly.im          = prod_t'(smp_q[`MULT_LAT-1].im) <<< `TW_FRAC;

endmodule

// ==== csd_twiddle_mult.sv ====
`include "fft_consts.svh"

module csd_twiddle_mult (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  fft_pkg::cplx_sample_t sample,
  input  logic                  use_unity,
  input  logic                  block_start,
  branch_if.source              rot
);
  import fft_pkg::*;

  // x * 362 as 512 - 128 - 32 + 8 + 2
  function automatic prod_t times_362(sample_t x);
    prod_t xe;
    xe = prod_t'(x);
    return (xe <<< 9) - (xe <<< 7) - (xe <<< 5) + (xe <<< 3) + (xe <<< 1);
  endfunction

  // x * -363 as -512 + 128 + 16 + 4 + 1
  function automatic prod_t times_m363(sample_t x);
    prod_t xe;
    xe = prod_t'(x);
    return -(xe <<< 9) + (xe <<< 7) + (xe <<< 4) + (xe <<< 2) + xe;
  endfunction

  // Stage 1 partial products
  prod_t pp_re_cr;  // re * cos term
  prod_t pp_im_cr;  // im * cos term
  prod_t pp_re_ci;  // re * sin term
  prod_t pp_im_ci;  // im * sin term
  logic  s1_valid;
  logic  s1_block_start;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid       <= 1'b0;
      s1_block_start <= 1'b0;
    end else begin
      s1_valid       <= in_valid;
      s1_block_start <= in_valid & block_start;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      if (use_unity) begin
        // Plain Q9 scaling, cross terms vanish
        pp_re_cr <= prod_t'(sample.re) <<< `TW_FRAC;
        pp_im_cr <= prod_t'(sample.im) <<< `TW_FRAC;
        pp_re_ci <= '0;
        pp_im_ci <= '0;
      end else begin
        pp_re_cr <= times_362(sample.re);
        pp_im_cr <= times_362(sample.im);
        pp_re_ci <= times_m363(sample.re);
        pp_im_ci <= times_m363(sample.im);
      end
    end
  end

  // Stage 2 combines into the rotated sample
  always_ff @(posedge clk) begin
    if (rst) begin
      rot.valid       <= 1'b0;
      rot.block_start <= 1'b0;
    end else begin
      rot.valid       <= s1_valid;
      rot.block_start <= s1_block_start;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      rot.re <= pp_re_cr - pp_im_ci;  // re*c - im*s
      rot.im <= pp_re_ci + pp_im_cr;  // re*s + im*c
    end
  end

endmodule

// ==== twiddle_sequencer.sv ====
`include "fft_consts.svh"

module twiddle_sequencer (
  input  logic clk,
  input  logic rst,
  input  logic in_valid,
  output logic use_unity,
  output logic block_start
);

  localparam int CNT_W = $clog2(`TW_HOLD);

  logic [CNT_W-1:0] pair_cnt;  // Position inside the current block
  logic             phase;     // Low for unity, high for W8^1

  // Only valid pairs advance the count
  always_ff @(posedge clk) begin
    if (rst) begin
      pair_cnt <= '0;
      phase    <= 1'b0;
    end else if (in_valid) begin
      if (pair_cnt == CNT_W'(`TW_HOLD - 1)) begin
        pair_cnt <= '0;
        phase    <= ~phase;  // Swap twiddle on wrap
      end else begin
        pair_cnt <= pair_cnt + 1'b1;
      end
    end
  end

  // Both describe the pair currently at the input
  assign use_unity   = ~phase;
  assign block_start = (pair_cnt == '0);

endmodule

// ==== branch_if.sv ====
`include "fft_consts.svh"

interface branch_if;
  import fft_pkg::*;

  logic  valid;
  prod_t re;           // Q9 scaled
  prod_t im;
  logic  block_start;  // First pair of a twiddle block

  // Producer side of a branch
  modport source (
    output valid,
    output re,
    output im,
    output block_start
  );

  // Butterfly side
  modport sink (
    input valid,
    input re,
    input im,
    input block_start
  );

endinterface

// ==== fft_pkg.sv ====
`include "fft_consts.svh"

package fft_pkg;

  // One part of an input sample
  typedef logic signed [`SAMPLE_W-1:0] sample_t;

  // Real part sits in the upper half
  typedef struct packed {
    sample_t re;
    sample_t im;
  } cplx_sample_t;

  // Rotated branch part in Q9 scale
  typedef logic signed [`PROD_W-1:0] prod_t;

  // Butterfly output part, one bit of growth over prod_t
  typedef logic signed [`OUT_W-1:0] out_t;

endpackage

// ==== fft_consts.svh ====
`ifndef FFT_CONSTS_SVH
`define FFT_CONSTS_SVH

// Sample and coefficient widths
`define SAMPLE_W 12   // One real or imaginary part
`define COEF_W   11   // Twiddle coefficient incl. sign
`define TW_FRAC  9    // Q9 twiddles, unity = 512

// Data path widths after rotation and butterfly
`define PROD_W   24
`define OUT_W    25

// Pairs per twiddle phase
`define TW_HOLD  8

// Both branches must see the same pipeline depth
`define MULT_LAT 2

`endif
